// File: fillrect_pkg.sv
// ========================================
// Rectangle fill engine shared definitions
// Panel geometry, field types, bus structs
// ========================================
package fillrect_pkg;

    // Panel geometry
    localparam int unsigned PANEL_COLS = 320;
    localparam int unsigned PANEL_ROWS = 16;
    localparam int unsigned BYTES_PER_PIXEL = 3;
    localparam int unsigned COL_FIELD_BYTES = 2;

    // Total bytes held by the frame buffer
    localparam int unsigned FB_BYTES = PANEL_COLS * PANEL_ROWS * BYTES_PER_PIXEL;

    typedef logic [15:0] col_addr_t;
    typedef logic [7:0] row_addr_t;
    typedef logic [1:0] pixel_idx_t;

    // Byte 2 is the first colour byte on the command stream
    typedef struct packed {
        logic [2:0][7:0] bytes;
    } color_t;

    typedef struct packed {
        row_addr_t  row;
        col_addr_t  col;
        pixel_idx_t pixel;
    } fb_addr_t;

    typedef struct packed {
        fb_addr_t   addr;
        logic [7:0] data;
        logic       en;
    } fb_write_t;

    typedef struct packed {
        col_addr_t x1;
        row_addr_t y1;
        col_addr_t width;
        row_addr_t height;
        color_t    color;
    } fill_req_t;

endpackage

// File: fillrect_cmd_fsm.sv
// ========================================
// Fill command FSM
// Captures command bytes, sequences a fill
// ========================================
`timescale 1ns/100ps

module fillrect_cmd_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [7:0]              data_in,
    input  logic                    enable,
    input  logic                    scan_done,
    output logic                    ready_for_data,
    output logic                    start,
    output fillrect_pkg::fill_req_t req,
    output logic                    done
);

    typedef enum logic [2:0] {
        ST_X1,
        ST_Y1,
        ST_WIDTH,
        ST_HEIGHT,
        ST_COLOR,
        ST_START,
        ST_RUNNING,
        ST_DONE
    } state_t;

    state_t                   state;
    fillrect_pkg::pixel_idx_t byte_cnt;
    logic                     accept;

    assign accept = enable && ready_for_data;

    // One cycle pulse to the scan counter
    assign start = (state == ST_START);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_X1;
            byte_cnt <= fillrect_pkg::pixel_idx_t'(fillrect_pkg::COL_FIELD_BYTES - 1);
            ready_for_data <= 1'b1;
            done <= 1'b0;
            req <= '0;
        end else begin
            case (state)
                ST_X1: begin
                    if (accept) begin
                        // High byte arrives first
                        req.x1 <= {req.x1[7:0], data_in};
                        if (byte_cnt == '0) begin
                            byte_cnt <= fillrect_pkg::pixel_idx_t'(
                                fillrect_pkg::COL_FIELD_BYTES - 1);
                            state <= ST_Y1;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                        end
                    end
                end
                ST_Y1: begin
                    if (accept) begin
                        req.y1 <= data_in;
                        state <= ST_WIDTH;
                    end
                end
                ST_WIDTH: begin
                    if (accept) begin
                        req.width <= {req.width[7:0], data_in};
                        if (byte_cnt == '0) begin
                            state <= ST_HEIGHT;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                        end
                    end
                end
                ST_HEIGHT: begin
                    if (accept) begin
                        req.height <= data_in;
                        byte_cnt <= fillrect_pkg::pixel_idx_t'(
                            fillrect_pkg::BYTES_PER_PIXEL - 1);
                        state <= ST_COLOR;
                    end
                end
                ST_COLOR: begin
                    if (accept) begin
                        req.color.bytes[byte_cnt] <= data_in;
                        if (byte_cnt == '0) begin
                            ready_for_data <= 1'b0;
                            state <= ST_START;
                        end else begin
                            byte_cnt <= byte_cnt - 1'b1;
                        end
                    end
                end
                ST_START: begin
                    state <= ST_RUNNING;
                end
                ST_RUNNING: begin
                    if (scan_done) begin
                        done <= 1'b1;
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // Back to idle, request cleared for the next command
                    done <= 1'b0;
                    ready_for_data <= 1'b1;
                    req <= '0;
                    byte_cnt <= fillrect_pkg::pixel_idx_t'(fillrect_pkg::COL_FIELD_BYTES - 1);
                    state <= ST_X1;
                end
                default: begin
                    state <= ST_X1;
                end
            endcase
        end
    end

endmodule

// File: fill_area_scan.sv
// ========================================
// Fill area scan counter
// Walks the rectangle, one byte per clock
// ========================================
`timescale 1ns/100ps

module fill_area_scan (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  fillrect_pkg::fill_req_t req,
    output fillrect_pkg::fb_write_t wr,
    output logic                    scan_done
);

    logic                     active;
    fillrect_pkg::pixel_idx_t pix;
    fillrect_pkg::col_addr_t  col_off;
    fillrect_pkg::row_addr_t  row_off;
    logic                     last_pix;
    logic                     last_col;
    logic                     last_row;
    logic [16:0]              col_sum;
    logic [8:0]               row_sum;

    assign last_pix = (pix == fillrect_pkg::pixel_idx_t'(fillrect_pkg::BYTES_PER_PIXEL - 1));
    assign last_col = (col_off == req.width - fillrect_pkg::col_addr_t'(1));
    assign last_row = (row_off == req.height - fillrect_pkg::row_addr_t'(1));

    // Carry out means the address wrapped, so that byte is dropped
    assign col_sum = {1'b0, req.x1} + {1'b0, col_off};
    assign row_sum = {1'b0, req.y1} + {1'b0, row_off};

    always_comb begin
        wr.addr.row = row_sum[7:0];
        wr.addr.col = col_sum[15:0];
        wr.addr.pixel = pix;
        wr.data = req.color.bytes[pix];
        wr.en = active && !col_sum[16] && !row_sum[8];
    end

    // Pixel index fastest, then column, then row
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            scan_done <= 1'b0;
            pix <= '0;
            col_off <= '0;
            row_off <= '0;
        end else begin
            scan_done <= 1'b0;
            if (start) begin
                pix <= '0;
                col_off <= '0;
                row_off <= '0;
                if (req.width != '0 && req.height != '0) begin
                    active <= 1'b1;
                end else begin
                    scan_done <= 1'b1;
                end
            end else if (active) begin
                if (!last_pix) begin
                    pix <= pix + 1'b1;
                end else begin
                    pix <= '0;
                    if (!last_col) begin
                        col_off <= col_off + 1'b1;
                    end else begin
                        col_off <= '0;
                        if (!last_row) begin
                            row_off <= row_off + 1'b1;
                        end else begin
                            active <= 1'b0;
                            scan_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: frame_buffer.sv
// ========================================
// Panel frame buffer
// Clipped byte writes, registered readback
// ========================================
`timescale 1ns/100ps

module frame_buffer (
    input  logic                    clk,
    input  fillrect_pkg::fb_write_t wr,
    input  fillrect_pkg::fb_addr_t  rd_addr,
    output logic [7:0]              rd_data
);

    logic [7:0] mem [fillrect_pkg::FB_BYTES];
    logic       wr_in_panel;
    logic       rd_in_panel;

    function automatic int unsigned lin_index(fillrect_pkg::fb_addr_t a);
        lin_index = (int'(a.row) * fillrect_pkg::PANEL_COLS + int'(a.col))
                    * fillrect_pkg::BYTES_PER_PIXEL + int'(a.pixel);
    endfunction

    function automatic logic in_panel(fillrect_pkg::fb_addr_t a);
        in_panel = (a.row < fillrect_pkg::PANEL_ROWS) && (a.col < fillrect_pkg::PANEL_COLS)
                   && (a.pixel < fillrect_pkg::BYTES_PER_PIXEL);
    endfunction

    assign wr_in_panel = in_panel(wr.addr);
    assign rd_in_panel = in_panel(rd_addr);

    always_ff @(posedge clk) begin
        // Writes off the panel edge are clipped
        if (wr.en && wr_in_panel) begin
            mem[lin_index(wr.addr)] <= wr.data;
        end
        // Reads off the panel return zero
        if (rd_in_panel) begin
            rd_data <= mem[lin_index(rd_addr)];
        end else begin
            rd_data <= 8'h00;
        end
    end

endmodule

// File: fillrect_engine.sv
// ========================================
// Rectangle fill engine top level
// ========================================
`timescale 1ns/100ps

module fillrect_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             data_in,
    input  logic                   enable,
    input  fillrect_pkg::fb_addr_t rd_addr,
    output logic                   ready_for_data,
    output logic                   done,
    output logic [7:0]             rd_data
);

    fillrect_pkg::fill_req_t req;
    fillrect_pkg::fb_write_t wr;
    logic                    start;
    logic                    scan_done;

    fillrect_cmd_fsm i_cmd_fsm (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .enable         (enable),
        .scan_done      (scan_done),
        .ready_for_data (ready_for_data),
        .start          (start),
        .req            (req),
        .done           (done)
    );

    fill_area_scan i_scan (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .req       (req),
        .wr        (wr),
        .scan_done (scan_done)
    );

    frame_buffer i_frame_buffer (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: fillrect_props.sv
// ========================================
// Fill engine handshake assertions
// ========================================
`timescale 1ns/100ps

module fillrect_props (
    input logic clk,
    input logic reset,
    input logic done,
    input logic ready_for_data,
    input logic start,
    input logic wr_en
);

    int assert_errors = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_errors++;
        end

    // Together these keep ready_for_data low from start until done
    busy_at_start: assert property (@(posedge clk) disable iff (reset) start |-> !ready_for_data)
        else begin
            $error("ready_for_data high while start is pulsed");
            assert_errors++;
        end

    ready_after_done: assert property (@(posedge clk) disable iff (reset)
        $rose(ready_for_data) |-> $past(done))
        else begin
            $error("ready_for_data rose without a preceding done");
            assert_errors++;
        end

    // ready_for_data is high exactly in the capture states
    no_write_capturing: assert property (@(posedge clk) disable iff (reset)
        ready_for_data |-> !wr_en)
        else begin
            $error("frame buffer write during command capture");
            assert_errors++;
        end

endmodule

bind fillrect_engine fillrect_props i_props (
    .clk            (clk),
    .reset          (reset),
    .done           (done),
    .ready_for_data (ready_for_data),
    .start          (start),
    .wr_en          (wr.en)
);

// File: fillrect_checker.sv
// ========================================
// Fill engine checker with a frame model
// ========================================
`timescale 1ns/100ps

module fillrect_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             data_in,
    input  logic                   enable,
    input  logic                   ready_for_data,
    input  logic                   done,
    input  logic                   rd_check,
    input  fillrect_pkg::fb_addr_t rd_addr,
    input  logic [7:0]             rd_data,
    output int                     error_count,
    output int                     done_count
);

    logic [7:0]             model [fillrect_pkg::FB_BYTES];
    logic [7:0]             cmd_bytes [9];
    int                     byte_cnt;
    string                  test_name = "none";
    logic                   pend_valid;
    fillrect_pkg::fb_addr_t pend_addr;
    logic                   done_d;
    logic [7:0]             expected;

    task automatic set_test(input string name);
        test_name = name;
    endtask

    function automatic int model_index(input int r, input int c, input int p);
        return (r * fillrect_pkg::PANEL_COLS + c) * fillrect_pkg::BYTES_PER_PIXEL + p;
    endfunction

    // Colour byte p is command byte 8 - p, pixels off the panel are dropped
    task automatic apply_fill();
        int x1;
        int y1;
        int w;
        int h;
        int r;
        int c;
        int p;
        x1 = {cmd_bytes[0], cmd_bytes[1]};
        y1 = cmd_bytes[2];
        w = {cmd_bytes[3], cmd_bytes[4]};
        h = cmd_bytes[5];
        for (r = y1; r < y1 + h && r < fillrect_pkg::PANEL_ROWS; r++) begin
            for (c = x1; c < x1 + w && c < fillrect_pkg::PANEL_COLS; c++) begin
                for (p = 0; p < fillrect_pkg::BYTES_PER_PIXEL; p++) begin
                    model[model_index(r, c, p)] = cmd_bytes[8 - p];
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            byte_cnt = 0;
            error_count = 0;
            done_count = 0;
            pend_valid <= 1'b0;
            done_d <= 1'b0;
        end else begin
            if (enable && ready_for_data) begin
                cmd_bytes[byte_cnt] = data_in;
                byte_cnt++;
                if (byte_cnt == 9) begin
                    apply_fill();
                    byte_cnt = 0;
                end
            end
            if (done) begin
                done_count++;
            end
            if (done_d && !ready_for_data) begin
                $display("ERROR: ready_for_data did not return high after done in %s",
                         test_name);
                error_count++;
            end
            done_d <= done;
            // Read data belongs to the address seen one cycle earlier
            if (pend_valid) begin
                expected = model[model_index(pend_addr.row, pend_addr.col, pend_addr.pixel)];
                if (rd_data !== expected) begin
                    $display("MISMATCH %s: row %0d col %0d byte %0d expected %h actual %h",
                             test_name, pend_addr.row, pend_addr.col, pend_addr.pixel,
                             expected, rd_data);
                    error_count++;
                end
            end
            pend_valid <= rd_check;
            pend_addr <= rd_addr;
        end
    end

endmodule

// File: tb_fillrect.sv
// ========================================
// Rectangle fill engine testbench
// Command table, stimulus, readback sweep
// ========================================
`timescale 1ns/100ps

module tb_fillrect;

    localparam int NUM_CMDS = 8;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_READS = 32;

    logic                   clk;
    logic                   reset;
    logic [7:0]             data_in;
    logic                   enable;
    fillrect_pkg::fb_addr_t rd_addr;
    logic                   rd_check;
    logic                   ready_for_data;
    logic                   done;
    logic [7:0]             rd_data;
    int                     chk_errors;
    int                     done_count;
    int                     tb_errors;
    int                     i;

    string                   names [NUM_CMDS];
    fillrect_pkg::fill_req_t cmds [NUM_CMDS];
    bit                      gapped [NUM_CMDS];

    fillrect_engine i_fillrect_engine (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .enable         (enable),
        .rd_addr        (rd_addr),
        .ready_for_data (ready_for_data),
        .done           (done),
        .rd_data        (rd_data)
    );

    fillrect_checker i_checker (
        .clk            (clk),
        .reset          (reset),
        .data_in        (data_in),
        .enable         (enable),
        .ready_for_data (ready_for_data),
        .done           (done),
        .rd_check       (rd_check),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .error_count    (chk_errors),
        .done_count     (done_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic set_cmd(input int idx, input string name, input int x1, input int y1,
                           input int w, input int h, input logic [23:0] color, input bit gaps);
        names[idx] = name;
        cmds[idx].x1 = fillrect_pkg::col_addr_t'(x1);
        cmds[idx].y1 = fillrect_pkg::row_addr_t'(y1);
        cmds[idx].width = fillrect_pkg::col_addr_t'(w);
        cmds[idx].height = fillrect_pkg::row_addr_t'(h);
        cmds[idx].color = color;
        gapped[idx] = gaps;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] value);
        int cycles;
        cycles = 0;
        while (!ready_for_data && cycles < TIMEOUT_CYCLES) begin
            idle(1);
            cycles++;
        end
        if (!ready_for_data) begin
            $display("ERROR: timed out waiting for ready_for_data");
            tb_errors++;
        end
        data_in = value;
        enable = 1'b1;
        idle(1);
        enable = 1'b0;
    endtask

    task automatic send_command(input int idx);
        logic [7:0] bytes_out [9];
        int         k;
        bytes_out[0] = cmds[idx].x1[15:8];
        bytes_out[1] = cmds[idx].x1[7:0];
        bytes_out[2] = cmds[idx].y1;
        bytes_out[3] = cmds[idx].width[15:8];
        bytes_out[4] = cmds[idx].width[7:0];
        bytes_out[5] = cmds[idx].height;
        // Colour goes out most significant byte first
        bytes_out[6] = cmds[idx].color.bytes[2];
        bytes_out[7] = cmds[idx].color.bytes[1];
        bytes_out[8] = cmds[idx].color.bytes[0];
        for (k = 0; k < 9; k++) begin
            send_byte(bytes_out[k]);
            if (gapped[idx]) begin
                idle(2);
            end
        end
        // Junk bytes while the fill runs, must be ignored
        if (gapped[idx]) begin
            data_in = 8'hFF;
            enable = 1'b1;
            idle(3);
            enable = 1'b0;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            idle(1);
            cycles++;
        end
        if (!done) begin
            $display("ERROR: timed out waiting for done");
            tb_errors++;
        end
    endtask

    task automatic read_byte(input int r, input int c, input int p);
        rd_addr.row = fillrect_pkg::row_addr_t'(r);
        rd_addr.col = fillrect_pkg::col_addr_t'(c);
        rd_addr.pixel = fillrect_pkg::pixel_idx_t'(p);
        rd_check = 1'b1;
        idle(1);
    endtask

    // Bounding area of the rectangle plus a one pixel border, kept on the panel
    task automatic sweep_area(input int idx);
        int r_lo;
        int r_hi;
        int c_lo;
        int c_hi;
        int r;
        int c;
        int p;
        r_lo = (int'(cmds[idx].y1) > 0) ? int'(cmds[idx].y1) - 1 : 0;
        r_hi = int'(cmds[idx].y1) + int'(cmds[idx].height);
        r_hi = (r_hi > fillrect_pkg::PANEL_ROWS - 1) ? fillrect_pkg::PANEL_ROWS - 1 : r_hi;
        c_lo = (int'(cmds[idx].x1) > 0) ? int'(cmds[idx].x1) - 1 : 0;
        c_hi = int'(cmds[idx].x1) + int'(cmds[idx].width);
        c_hi = (c_hi > fillrect_pkg::PANEL_COLS - 1) ? fillrect_pkg::PANEL_COLS - 1 : c_hi;
        // A rectangle past the top of a field would wrap onto the low edge
        if (r_hi + 1 > (1 << $bits(fillrect_pkg::row_addr_t))) begin
            r_lo = 0;
        end
        if (int'(cmds[idx].x1) + int'(cmds[idx].width) > (1 << $bits(fillrect_pkg::col_addr_t)))
        begin
            c_lo = 0;
        end
        if (int'(cmds[idx].y1) + int'(cmds[idx].height) > (1 << $bits(fillrect_pkg::row_addr_t)))
        begin
            r_lo = 0;
        end
        for (r = r_lo; r <= r_hi; r++) begin
            for (c = c_lo; c <= c_hi; c++) begin
                for (p = 0; p < fillrect_pkg::BYTES_PER_PIXEL; p++) begin
                    read_byte(r, c, p);
                end
            end
        end
        for (r = 0; r < RANDOM_READS; r++) begin
            read_byte($urandom % fillrect_pkg::PANEL_ROWS, $urandom % fillrect_pkg::PANEL_COLS,
                      $urandom % fillrect_pkg::BYTES_PER_PIXEL);
        end
        rd_check = 1'b0;
        idle(1);
    endtask

    initial begin
        void'($urandom(32'h14d));
        set_cmd(0, "full_panel", 0, 0, 320, 16, 24'h112233, 1'b0);
        set_cmd(1, "small_rect", 10, 3, 5, 4, 24'hA0B0C0, 1'b0);
        set_cmd(2, "clip_right", 300, 2, 40, 3, 24'h445566, 1'b0);
        set_cmd(3, "clip_bottom", 260, 12, 10, 10, 24'h778899, 1'b0);
        set_cmd(4, "zero_width", 5, 5, 0, 3, 24'hFFFFFF, 1'b0);
        set_cmd(5, "zero_height", 5, 5, 3, 0, 24'hEEEEEE, 1'b0);
        set_cmd(6, "gapped_enable", 100, 7, 6, 2, 24'h123456, 1'b1);
        set_cmd(7, "no_wrap", 65530, 250, 20, 10, 24'h5A5A5A, 1'b0);
        reset = 1'b1;
        data_in = 8'h00;
        enable = 1'b0;
        rd_addr = '0;
        rd_check = 1'b0;
        tb_errors = 0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (i = 0; i < NUM_CMDS; i++) begin
            i_checker.set_test(names[i]);
            send_command(i);
            wait_done();
            sweep_area(i);
        end
        if (done_count != NUM_CMDS) begin
            $display("ERROR: saw %0d done pulses for %0d commands", done_count, NUM_CMDS);
            tb_errors++;
        end
        $display("Error counts: checker %0d, testbench %0d, assertions %0d", chk_errors,
                 tb_errors, i_fillrect_engine.i_props.assert_errors);
        if (chk_errors + tb_errors + i_fillrect_engine.i_props.assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
fillrect_pkg.sv
fillrect_cmd_fsm.sv
fill_area_scan.sv
frame_buffer.sv
fillrect_engine.sv
fillrect_props.sv
fillrect_checker.sv
tb_fillrect.sv

// File: Bender.yml
package:
  name: fillrect

sources:
  - fillrect_pkg.sv
  - fillrect_cmd_fsm.sv
  - fill_area_scan.sv
  - frame_buffer.sv
  - fillrect_engine.sv
  - target: test
    files:
      - fillrect_props.sv
      - fillrect_checker.sv
      - tb_fillrect.sv
